//--- common/qspi_capture_if.sv
`default_nettype none

interface qspi_capture_if
    import qspi_proto_pkg::*;
();

    logic       start;
    read_mode_e mode;
    logic [7:0] data;       // Valid with done
    logic       done;

    modport seq (
        output start,
        output mode,
        input  data,
        input  done
    );

    modport capture (
        input  start,
        input  mode,
        output data,
        output done
    );

endinterface

`default_nettype wire

//--- common/qspi_ctrl_pkg.sv
`default_nettype none

package qspi_ctrl_pkg;

    typedef enum logic [2:0] {
        idle       = 3'd0,
        die_frame  = 3'd1,
        die_gap    = 3'd2,    // One cycle of cs_n high
        read_frame = 3'd3,
        capture    = 3'd4,
        complete   = 3'd5
    } seq_state_e;

endpackage

`default_nettype wire

//--- common/qspi_defines.svh
`ifndef QSPI_DEFINES_SVH
`define QSPI_DEFINES_SVH

// Command bytes
`define QSPI_SWITCH_CMD      8'hC2
`define QSPI_DIE_NUM         8'h01
`define QSPI_READ_CMD        8'h13
`define QSPI_DUAL_READ_CMD   8'h3C
`define QSPI_QUAD_READ_CMD   8'h6C

// Frame geometry in bits
`define QSPI_ADDR_BITS       32
`define QSPI_FRAME_BITS      40
`define QSPI_SWITCH_BITS     16

// Turnaround after the frame, in cycles
`define QSPI_WAIT_SINGLE     5'd1
`define QSPI_WAIT_MULTI      5'd9

// Sample edges needed for one byte
`define QSPI_SAMPLES_SINGLE  5'd8
`define QSPI_SAMPLES_DUAL    5'd4
`define QSPI_SAMPLES_QUAD    5'd2

`endif

//--- common/qspi_proto_pkg.sv
`default_nettype none

`include "qspi_defines.svh"

package qspi_proto_pkg;

    typedef enum logic [1:0] {
        single     = 2'b00,
        dual       = 2'b01,
        quad       = 2'b10,
        single_alt = 2'b11     // Same as single
    } read_mode_e;

    // Opcode then address
    typedef struct packed {
        logic [7:0]                 opcode;
        logic [`QSPI_ADDR_BITS-1:0] addr;
    } read_frame_t;

    // Only the top 16 bits go out
    typedef struct packed {
        logic [7:0]                                   opcode;
        logic [7:0]                                   die_num;
        logic [`QSPI_FRAME_BITS-`QSPI_SWITCH_BITS-1:0] unused;
    } die_frame_t;

    // One shift word, sent MSB first in either view
    typedef union packed {
        read_frame_t rd;
        die_frame_t  die;
    } qspi_frame_u;

endpackage

`default_nettype wire

//--- common/qspi_shift_if.sv
`default_nettype none

interface qspi_shift_if
    import qspi_proto_pkg::*;
();

    logic        start;     // One cycle pulse
    logic        is_die;    // Held with start
    qspi_frame_u frame;
    logic        done;      // Edge after the last bit

    modport seq (
        output start,
        output is_die,
        output frame,
        input  done
    );

    modport shifter (
        input  start,
        input  is_die,
        input  frame,
        output done
    );

endinterface

`default_nettype wire

//--- qspi_controller/qspi_controller.sv
`default_nettype none

module qspi_controller (
    input  wire        system_clk,
    input  wire        system_reset_n,
    input  wire        read_flag,
    input  wire [31:0] read_addr,
    input  wire        switch_die,
    input  wire [1:0]  mode,
    input  wire [3:0]  io_in,
    output wire        spi_clk,
    output wire        spi_cs_n,
    output wire        io_out,
    output wire        io_oe,
    output wire [7:0]  fifo_data,
    output wire        write_req,
    output wire        read_done
);

    qspi_shift_if   shift_bus ();
    qspi_capture_if cap_bus ();

    // Flash sees a rising edge mid-bit since logic moves on the falling edge
    assign spi_clk = system_clk & system_reset_n;

    qspi_sequencer u_sequencer (
        .system_clk     (system_clk),
        .system_reset_n (system_reset_n),
        .read_flag      (read_flag),
        .read_addr      (read_addr),
        .switch_die     (switch_die),
        .mode           (mode),
        .shift          (shift_bus.seq),
        .cap            (cap_bus.seq),
        .spi_cs_n       (spi_cs_n),
        .fifo_data      (fifo_data),
        .write_req      (write_req),
        .read_done      (read_done)
    );

    qspi_frame_shifter u_shifter (
        .system_clk     (system_clk),
        .system_reset_n (system_reset_n),
        .shift          (shift_bus.shifter),
        .io_out         (io_out),
        .io_oe          (io_oe)
    );

    qspi_data_capture u_capture (
        .system_clk     (system_clk),
        .system_reset_n (system_reset_n),
        .io_in          (io_in),
        .cap            (cap_bus.capture)
    );

endmodule

`default_nettype wire

//--- qspi_controller/qspi_sequencer.sv
`default_nettype none

`include "qspi_defines.svh"

module qspi_sequencer
    import qspi_proto_pkg::*, qspi_ctrl_pkg::*;
(
    input  wire         system_clk,
    input  wire         system_reset_n,
    input  wire         read_flag,
    input  wire  [31:0] read_addr,
    input  wire         switch_die,
    input  wire  [1:0]  mode,
    qspi_shift_if.seq   shift,
    qspi_capture_if.seq cap,
    output logic        spi_cs_n,
    output logic [7:0]  fifo_data,
    output logic        write_req,
    output logic        read_done
);

    seq_state_e                 state;
    logic [`QSPI_ADDR_BITS-1:0] addr_q;
    read_mode_e                 mode_q;
    logic                       accept;
    logic                       die_end;

    function automatic logic [7:0] read_opcode(read_mode_e m);
        case (m)
            dual:    return `QSPI_DUAL_READ_CMD;
            quad:    return `QSPI_QUAD_READ_CMD;
            default: return `QSPI_READ_CMD;     // single and single_alt
        endcase
    endfunction

    assign accept  = (state == idle) && read_flag;
    assign die_end = (state == die_frame) && shift.done;

    // Capture starts on the edge io_oe falls
    assign cap.start = (state == read_frame) && shift.done;
    assign cap.mode  = mode_q;

    always_ff @(negedge system_clk)
    begin
        if (!system_reset_n)
        begin
            state        <= idle;
            spi_cs_n     <= 1'b1;
            shift.start  <= 1'b0;
            shift.is_die <= 1'b0;
            write_req    <= 1'b0;
            read_done    <= 1'b0;
        end
        else
        begin
            write_req <= 1'b0;
            read_done <= 1'b0;
            case (state)
                idle:
                begin
                    spi_cs_n <= 1'b1;
                    if (accept)
                    begin
                        shift.start  <= 1'b1;
                        shift.is_die <= switch_die;
                        state        <= switch_die ? die_frame : read_frame;
                    end
                end
                die_frame:
                begin
                    if (shift.start)
                    begin
                        spi_cs_n    <= 1'b0;    // Edge 0 of the die frame
                        shift.start <= 1'b0;
                    end
                    else if (die_end)
                    begin
                        spi_cs_n     <= 1'b1;
                        shift.start  <= 1'b1;   // Read frame goes next
                        shift.is_die <= 1'b0;
                        state        <= die_gap;
                    end
                end
                die_gap:
                begin
                    spi_cs_n    <= 1'b0;
                    shift.start <= 1'b0;
                    state       <= read_frame;
                end
                read_frame:
                begin
                    if (shift.start)
                    begin
                        spi_cs_n    <= 1'b0;
                        shift.start <= 1'b0;
                    end
                    else if (shift.done)
                    begin
                        state <= capture;
                    end
                end
                capture:
                begin
                    if (cap.done)
                    begin
                        write_req <= 1'b1;
                        spi_cs_n  <= 1'b1;
                        state     <= complete;
                    end
                end
                complete:
                begin
                    read_done <= 1'b1;
                    state     <= idle;
                end
                default:
                begin
                    state <= idle;
                end
            endcase
        end
    end

    // Request fields and the frame word
    always_ff @(negedge system_clk)
    begin
        if (accept)
        begin
            addr_q <= read_addr;
            mode_q <= read_mode_e'(mode);
            if (switch_die)
            begin
                shift.frame.die.opcode  <= `QSPI_SWITCH_CMD;
                shift.frame.die.die_num <= `QSPI_DIE_NUM;
                shift.frame.die.unused  <= '0;
            end
            else
            begin
                shift.frame.rd.opcode <= read_opcode(read_mode_e'(mode));
                shift.frame.rd.addr   <= read_addr;
            end
        end
        else if (die_end)
        begin
            shift.frame.rd.opcode <= read_opcode(mode_q);
            shift.frame.rd.addr   <= addr_q;
        end

        if ((state == capture) && cap.done)
            fifo_data <= cap.data;
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the QSPI controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module qspi_controller_tb -f verilog.f -o qspi_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/qspi_sim > "$log" 2>&1
status=$?
cat "$log"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^NO ERRORS$" "$log"; then
    echo "Result: pass"
    exit 0
fi

echo "Result: fail"
exit 1

//--- tb/qspi_controller_assert.sv
`default_nettype none

module qspi_controller_assert
    import qspi_ctrl_pkg::*;
(
    input wire             system_clk,
    input wire             system_reset_n,
    input wire             spi_cs_n,
    input wire             io_oe,
    input wire             write_req,
    input wire             read_done,
    input wire seq_state_e state
);

    timeunit 1ns;
    timeprecision 1ps;

    // Design moves on the falling edge
    a_write_req_single: assert property (@(negedge system_clk) disable iff (!system_reset_n)
        write_req |=> !write_req)
        else $error("write_req held for more than one cycle");

    a_oe_inside_cs: assert property (@(negedge system_clk) disable iff (!system_reset_n)
        !(io_oe && spi_cs_n))
        else $error("io_oe high while spi_cs_n is high");

    a_done_after_write: assert property (@(negedge system_clk) disable iff (!system_reset_n)
        write_req |=> read_done)
        else $error("read_done missing one edge after write_req");

    a_done_needs_write: assert property (@(negedge system_clk) disable iff (!system_reset_n)
        read_done |-> $past(write_req))
        else $error("read_done without write_req one edge before");

    a_idle_cs_high: assert property (@(negedge system_clk) disable iff (!system_reset_n)
        (state == idle) |-> spi_cs_n)
        else $error("spi_cs_n low while the sequencer is idle");

endmodule

bind qspi_controller qspi_controller_assert u_assert (
    .system_clk     (system_clk),
    .system_reset_n (system_reset_n),
    .spi_cs_n       (spi_cs_n),
    .io_oe          (io_oe),
    .write_req      (write_req),
    .read_done      (read_done),
    .state          (u_sequencer.state)
);

`default_nettype wire

//--- tb/qspi_controller_tb.sv
`default_nettype none

module qspi_controller_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_rows   = 7;
    localparam int max_frames = 32;
    localparam int done_limit = 300;    // Cycles per read

    logic        system_clk;
    logic        system_reset_n;
    logic        read_flag;
    logic [31:0] read_addr;
    logic        switch_die;
    logic [1:0]  mode;
    logic [3:0]  io_in;
    wire         spi_clk;
    wire         spi_cs_n;
    wire         io_out;
    wire         io_oe;
    wire  [7:0]  fifo_data;
    wire         write_req;
    wire         read_done;

    // Stimulus table
    string      row_name [num_rows] = '{"single_read", "dual_read", "quad_read",
                                        "alt_single_read", "die_single_read",
                                        "die_quad_read", "die_dual_read"};
    logic [1:0] row_mode [num_rows] = '{2'b00, 2'b01, 2'b10, 2'b11, 2'b00, 2'b10, 2'b01};
    logic       row_die  [num_rows] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
    logic [7:0] row_byte [num_rows] = '{8'hA5, 8'h3C, 8'hE7, 8'h5A, 8'hC3, 8'h96, 8'h71};

    // Flash model records with bit n of a frame at index n
    logic [63:0] frame_bits [max_frames];
    int          frame_len  [max_frames];
    int          gap_len    [max_frames];
    int          frame_count;
    int          edge_k;
    int          high_run;
    int          sample_idx;
    logic        cs_prev;
    logic [3:0]  next_io;
    logic [1:0]  flash_mode = 2'b00;
    logic [7:0]  flash_byte = 8'h00;

    int          wr_count    = 0;
    int          rd_count    = 0;
    int          rd_after_wr = 0;
    logic        wr_prev     = 1'b0;
    logic [7:0]  wr_data     = 8'h00;

    logic [31:0] lfsr;
    int          error_count;
    int          failed_tests;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // x^32 + x^22 + x^2 + x + 1
    endfunction

    task automatic next_address(output logic [31:0] a);
        a = '0;
        for (int n = 0; n < 32; n++)
        begin
            lfsr = lfsr_next(lfsr);
            a    = {a[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [7:0] expected_opcode(input logic [1:0] m);
        case (m)
            2'b01:   return 8'h3C;
            2'b10:   return 8'h6C;
            default: return 8'h13;
        endcase
    endfunction

    function automatic int turnaround_for(input logic [1:0] m);
        return (m == 2'b01 || m == 2'b10) ? 9 : 1;
    endfunction

    function automatic int samples_for(input logic [1:0] m);
        case (m)
            2'b01:   return 4;
            2'b10:   return 2;
            default: return 8;
        endcase
    endfunction

    // Unused lanes carry inverted data so a wrong lane shows up
    function automatic logic [3:0] lane_bits(input logic [1:0] m, input logic [7:0] b,
                                             input int i);
        logic [1:0] pair;
        logic       bit_v;
        case (m)
            2'b01:
            begin
                pair = b[7-2*i -: 2];
                return {~pair, pair};
            end
            2'b10:   return b[7-4*i -: 4];
            default:
            begin
                bit_v = b[7-i];
                return {1'b0, ~bit_v, bit_v, ~bit_v};
            end
        endcase
    endfunction

    function automatic logic [63:0] frame_word(input int idx, input int nbits);
        logic [63:0] w;
        w = '0;
        for (int n = 0; n < nbits; n++)
            w = {w[62:0], frame_bits[idx][n]};
        return w;
    endfunction

    task automatic report_mismatch(input string name, input string what,
                                   input logic [63:0] exp_v, input logic [63:0] act_v);
        $display("[FAIL] %s %s expected %0h actual %0h", name, what, exp_v, act_v);
        error_count++;
    endtask

    task automatic report_problem(input string name, input string text);
        $display("[ERROR] %s: %s", name, text);
        error_count++;
    endtask

    qspi_controller UUT (
        .system_clk     (system_clk),
        .system_reset_n (system_reset_n),
        .read_flag      (read_flag),
        .read_addr      (read_addr),
        .switch_die     (switch_die),
        .mode           (mode),
        .io_in          (io_in),
        .spi_clk        (spi_clk),
        .spi_cs_n       (spi_cs_n),
        .io_out         (io_out),
        .io_oe          (io_oe),
        .fifo_data      (fifo_data),
        .write_req      (write_req),
        .read_done      (read_done)
    );

    initial
    begin
        system_clk = 1'b0;
        forever #10 system_clk = ~system_clk;
    end

    // Flash model looks at the bus mid-bit and sets io_in for the next falling edge
    initial
    begin
        io_in       = 4'hA;
        cs_prev     = 1'b1;
        edge_k      = 0;
        high_run    = 0;
        frame_count = 0;
        forever
        begin
            @(posedge system_clk);
            if (!spi_cs_n)
            begin
                if (cs_prev)
                begin
                    edge_k = 0;     // Fall of cs_n
                    if (frame_count < max_frames)
                    begin
                        frame_bits[frame_count] = '0;
                        frame_len[frame_count]  = 0;
                        gap_len[frame_count]    = high_run;
                    end
                end
                else
                    edge_k = edge_k + 1;
                if (io_oe && frame_count < max_frames && edge_k < 64)
                begin
                    frame_bits[frame_count][edge_k] = io_out;
                    frame_len[frame_count]          = frame_len[frame_count] + 1;
                end
                high_run = 0;
            end
            else
            begin
                if (!cs_prev)
                    frame_count = frame_count + 1;
                high_run = high_run + 1;
            end
            cs_prev    = spi_cs_n;
            next_io    = 4'hA;
            sample_idx = edge_k + 1 - 40 - turnaround_for(flash_mode);
            if (!spi_cs_n && sample_idx >= 0 && sample_idx < samples_for(flash_mode))
                next_io = lane_bits(flash_mode, flash_byte, sample_idx);
            #2;
            io_in = next_io;
        end
    end

    always @(posedge system_clk)
    begin
        if (write_req)
        begin
            wr_count <= wr_count + 1;
            wr_data  <= fifo_data;
        end
        if (read_done)
        begin
            rd_count <= rd_count + 1;
            if (wr_prev)
                rd_after_wr <= rd_after_wr + 1;
        end
        wr_prev <= write_req;
    end

    task automatic run_row(input int r);
        logic [31:0] addr;
        logic [39:0] exp_frame;
        logic [63:0] word;
        int          errs_before;
        int          f0;
        int          wr0;
        int          rd0;
        int          ra0;
        int          nf;
        int          rf;
        int          cycles;
        errs_before = error_count;
        next_address(addr);
        exp_frame = {expected_opcode(row_mode[r]), addr};
        nf        = row_die[r] ? 2 : 1;
        if (spi_cs_n !== 1'b1)
            report_problem(row_name[r], "chip select still low before the request");
        f0         = frame_count;
        wr0        = wr_count;
        rd0        = rd_count;
        ra0        = rd_after_wr;
        flash_mode = row_mode[r];
        flash_byte = row_byte[r];
        read_flag  = 1'b1;
        read_addr  = addr;
        switch_die = row_die[r];
        mode       = row_mode[r];
        @(posedge system_clk);
        #2;
        // Request fields must be latched at accept
        read_flag  = 1'b0;
        read_addr  = ~addr;
        switch_die = ~row_die[r];
        mode       = ~row_mode[r];
        cycles     = 0;
        while (rd_count == rd0 && cycles < done_limit)
        begin
            @(posedge system_clk);
            cycles++;
        end
        if (rd_count == rd0)
            report_problem(row_name[r], "timed out waiting for read_done");
        if (wr_count - wr0 != 1)
            report_mismatch(row_name[r], "write_req pulses", 64'(1), 64'(wr_count - wr0));
        if (rd_count - rd0 != 1)
            report_mismatch(row_name[r], "read_done pulses", 64'(1), 64'(rd_count - rd0));
        if (rd_after_wr - ra0 != 1)
            report_problem(row_name[r], "read_done did not follow write_req by one cycle");
        if (wr_data !== row_byte[r])
            report_mismatch(row_name[r], "fifo_data", 64'(row_byte[r]), 64'(wr_data));
        if (frame_count - f0 != nf)
            report_mismatch(row_name[r], "frame count", 64'(nf), 64'(frame_count - f0));
        else
        begin
            rf = f0 + nf - 1;
            if (row_die[r])
            begin
                word = frame_word(f0, 16);
                if (frame_len[f0] != 16)
                    report_mismatch(row_name[r], "die frame bits", 64'(16), 64'(frame_len[f0]));
                if (word[15:0] !== 16'hC201)
                    report_mismatch(row_name[r], "die frame", 64'(16'hC201), word);
                if (gap_len[rf] != 1)
                    report_mismatch(row_name[r], "cs_n gap cycles", 64'(1), 64'(gap_len[rf]));
            end
            word = frame_word(rf, 40);
            if (frame_len[rf] != 40)
                report_mismatch(row_name[r], "read frame bits", 64'(40), 64'(frame_len[rf]));
            if (word[39:0] !== exp_frame)
                report_mismatch(row_name[r], "read frame", 64'(exp_frame), word);
        end
        #2;
        if (error_count == errs_before)
            $display("[PASS] %s", row_name[r]);
        else
        begin
            $display("[DONE] %s with %0d error(s)", row_name[r], error_count - errs_before);
            failed_tests++;
        end
    endtask

    initial
    begin
        system_reset_n = 1'b0;
        read_flag      = 1'b0;
        read_addr      = 32'h0;
        switch_die     = 1'b0;
        mode           = 2'b00;
        lfsr           = 32'h491b_e418;
        error_count    = 0;
        failed_tests   = 0;
        repeat (2) @(posedge system_clk);
        #2;
        // Clock is high here, so a gated spi_clk shows low
        if (spi_clk !== 1'b0)
            report_mismatch("reset_state", "spi_clk in reset", 64'(0), 64'(spi_clk));
        system_reset_n = 1'b1;
        repeat (2) @(posedge system_clk);
        if (spi_cs_n !== 1'b1)
            report_mismatch("reset_state", "spi_cs_n", 64'(1), 64'(spi_cs_n));
        if (io_oe !== 1'b0)
            report_mismatch("reset_state", "io_oe", 64'(0), 64'(io_oe));
        if (write_req !== 1'b0)
            report_mismatch("reset_state", "write_req", 64'(0), 64'(write_req));
        if (read_done !== 1'b0)
            report_mismatch("reset_state", "read_done", 64'(0), 64'(read_done));
        #2;
        if (spi_clk !== 1'b1)
            report_mismatch("reset_state", "spi_clk", 64'(1), 64'(spi_clk));
        if (error_count == 0)
            $display("[PASS] reset_state");
        else
        begin
            $display("[DONE] reset_state with %0d error(s)", error_count);
            failed_tests++;
        end
        for (int r = 0; r < num_rows; r++)
            run_row(r);
        $display("Tests run %0d, tests failed %0d, errors %0d",
                 num_rows + 1, failed_tests, error_count);
        if (error_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+common
common/qspi_proto_pkg.sv
common/qspi_ctrl_pkg.sv
common/qspi_shift_if.sv
common/qspi_capture_if.sv
verilog/qspi_frame_shifter.sv
verilog/qspi_data_capture.sv
qspi_controller/qspi_sequencer.sv
qspi_controller/qspi_controller.sv
tb/qspi_controller_assert.sv
tb/qspi_controller_tb.sv

//--- verilog/qspi_data_capture.sv
`default_nettype none

`include "qspi_defines.svh"

module qspi_data_capture
    import qspi_proto_pkg::*;
(
    input  wire             system_clk,
    input  wire             system_reset_n,
    input  wire  [3:0]      io_in,
    qspi_capture_if.capture cap
);

    logic [4:0] wait_cycles;
    logic [4:0] sample_cycles;
    logic [4:0] cnt;
    logic [4:0] edge_idx;
    logic       active;
    logic       sampling;
    logic       last_sample;
    logic [7:0] byte_q;
    logic [7:0] byte_next;

    // Lane rule per read type
    always_comb
    begin
        case (cap.mode)
            dual:
            begin
                wait_cycles   = `QSPI_WAIT_MULTI;
                sample_cycles = `QSPI_SAMPLES_DUAL;
                byte_next     = {byte_q[5:0], io_in[1:0]};
            end
            quad:
            begin
                wait_cycles   = `QSPI_WAIT_MULTI;
                sample_cycles = `QSPI_SAMPLES_QUAD;
                byte_next     = {byte_q[3:0], io_in[3:0]};
            end
            default:
            begin
                wait_cycles   = `QSPI_WAIT_SINGLE;
                sample_cycles = `QSPI_SAMPLES_SINGLE;
                byte_next     = {byte_q[6:0], io_in[1]};   // Flash drives io1
            end
        endcase
    end

    // Start pulse lands on the first edge after io_oe fell
    assign edge_idx = cap.start ? 5'd1 : cnt;

    assign sampling = (cap.start || active)
                      && (edge_idx >= wait_cycles)
                      && (edge_idx < wait_cycles + sample_cycles);

    assign last_sample = sampling
                         && (edge_idx == wait_cycles + sample_cycles - 5'd1);

    always_ff @(negedge system_clk)
    begin
        if (!system_reset_n)
        begin
            active   <= 1'b0;
            cnt      <= 5'd0;
            cap.done <= 1'b0;
        end
        else
        begin
            cap.done <= last_sample;    // Byte complete in byte_q
            active   <= (cap.start || active) && !last_sample;
            if (cap.start || active)
                cnt <= edge_idx + 5'd1;
        end
    end

    always_ff @(negedge system_clk)
    begin
        if (sampling)
            byte_q <= byte_next;
    end

    assign cap.data = byte_q;

endmodule

`default_nettype wire

//--- verilog/qspi_frame_shifter.sv
`default_nettype none

`include "qspi_defines.svh"

module qspi_frame_shifter
    import qspi_proto_pkg::*;
(
    input  wire           system_clk,
    input  wire           system_reset_n,
    qspi_shift_if.shifter shift,
    output logic          io_out,
    output logic          io_oe
);

    localparam logic [5:0] die_len   = 6'(`QSPI_SWITCH_BITS);
    localparam logic [5:0] frame_len = 6'(`QSPI_FRAME_BITS);

    qspi_frame_u shreg;
    logic [5:0]  bit_cnt;     // Bits already on io_out
    logic        active;
    logic        is_die_q;
    logic        last_bit;

    assign last_bit = active && (bit_cnt == (is_die_q ? die_len : frame_len));

    always_ff @(negedge system_clk)
    begin
        if (!system_reset_n)
        begin
            active     <= 1'b0;
            is_die_q   <= 1'b0;
            bit_cnt    <= 6'd0;
            io_out     <= 1'b0;
            io_oe      <= 1'b0;
            shift.done <= 1'b0;
        end
        else
        begin
            shift.done <= last_bit;
            if (shift.start)
            begin
                active   <= 1'b1;
                is_die_q <= shift.is_die;
                bit_cnt  <= 6'd1;
                io_oe    <= 1'b1;
                io_out   <= shift.frame.rd.opcode[7];   // MSB of either view
            end
            else if (last_bit)
            begin
                active <= 1'b0;
                io_oe  <= 1'b0;
                io_out <= 1'b0;
            end
            else if (active)
            begin
                io_out  <= shreg[`QSPI_FRAME_BITS-1];
                bit_cnt <= bit_cnt + 6'd1;
            end
        end
    end

    always_ff @(negedge system_clk)
    begin
        if (shift.start)
            shreg <= {shift.frame[`QSPI_FRAME_BITS-2:0], 1'b0};
        else if (active)
            shreg <= {shreg[`QSPI_FRAME_BITS-2:0], 1'b0};
    end

endmodule

`default_nettype wire
